// File: cache_params.svh
// ----------------------------------------------------------------------
// geometry macros of the data cache behind the miss-handling unit.
// ----------------------------------------------------------------------
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte address width.
`define CACHE_ADDR_WIDTH 32

// associativity, must be a power of two for the pseudo-tree LRU.
`define CACHE_WAYS 4

// number of sets.
`define CACHE_SETS 64

// line size.
`define CACHE_BLOCK_WORDS 8
`define CACHE_WORD_BYTES 4

`endif

// File: cache_geom_pkg.sv
// ----------------------------------------------------------------------
// address-field and per-way vector types, with address field helpers.
// ----------------------------------------------------------------------
`include "cache_params.svh"

package cache_geom_pkg;

  localparam int ADDR_WIDTH   = `CACHE_ADDR_WIDTH;
  localparam int WAYS         = `CACHE_WAYS;
  localparam int WAY_ID_WIDTH = $clog2(`CACHE_WAYS);
  localparam int INDEX_WIDTH  = $clog2(`CACHE_SETS);
  localparam int OFFSET_WIDTH = $clog2(`CACHE_BLOCK_WORDS * `CACHE_WORD_BYTES);
  localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int LRU_WIDTH    = WAYS - 1;

  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [TAG_WIDTH-1:0]    tag_t;
  typedef logic [INDEX_WIDTH-1:0]  index_t;
  typedef logic [WAY_ID_WIDTH-1:0] way_id_t;
  typedef logic [WAYS-1:0]         way_vec_t;
  typedef logic [LRU_WIDTH-1:0]    lru_bits_t;

  function automatic tag_t addr_tag(addr_t addr);
    return addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  endfunction

  function automatic index_t addr_index(addr_t addr);
    return addr[OFFSET_WIDTH +: INDEX_WIDTH];
  endfunction

  // rebuilds a line-aligned byte address from its tag and set index.
  function automatic addr_t line_addr(tag_t tag, index_t index);
    return {tag, index, {OFFSET_WIDTH{1'b0}}};
  endfunction

endpackage

// File: miss_if_pkg.sv
// ----------------------------------------------------------------------
// request, metadata, DMA and memory-write structs and command enums.
// ----------------------------------------------------------------------
package miss_if_pkg;

  import cache_geom_pkg::*;

  // the missed request as held by the tag-verify stage.
  typedef struct packed {
    addr_t addr;
    logic  ld_op;
    logic  st_op;
    logic  afl_op;
    logic  ainv_op;
    logic  aflinv_op;
  } miss_req_s;

  // tag-verify metadata of the addressed set.
  typedef struct packed {
    tag_t [WAYS-1:0] tag;
    way_vec_t        valid;
    way_vec_t        hit;
    way_id_t         hit_way;
    logic            hit_found;
  } way_meta_s;

  // one stat memory word, dirty bits and LRU tree of a set.
  typedef struct packed {
    way_vec_t  dirty;
    lru_bits_t lru;
  } stat_info_s;

  typedef enum logic [2:0] {
    e_dma_nop,
    e_dma_send_fill_addr,
    e_dma_send_evict_addr,
    e_dma_send_evict_data,
    e_dma_get_fill_data
  } dma_cmd_e;

  // held by the controller until the DMA engine returns done.
  typedef struct packed {
    dma_cmd_e cmd;
    way_id_t  way;
    addr_t    addr;
  } dma_req_s;

  typedef enum logic [1:0] {
    e_meta_none,
    e_meta_flush_clear,
    e_meta_fill_commit
  } meta_op_e;

  typedef struct packed {
    logic       valid;
    index_t     index;
    stat_info_s data;
    stat_info_s mask;
  } stat_wr_s;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_info_s;

  typedef struct packed {
    logic                 valid;
    index_t               index;
    tag_info_s [WAYS-1:0] data;
    tag_info_s [WAYS-1:0] mask;
  } tag_wr_s;

endpackage

// File: plru_tree.sv
// ----------------------------------------------------------------------
// pseudo-tree LRU way encoder and MRU update decoder.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module plru_tree (
  input  cache_geom_pkg::lru_bits_t lru_i,
  input  cache_geom_pkg::way_id_t   way_i,
  output cache_geom_pkg::way_id_t   lru_way_o,
  output cache_geom_pkg::lru_bits_t upd_data_o,
  output cache_geom_pkg::lru_bits_t upd_mask_o
);

  import cache_geom_pkg::*;

  // nodes are stored heap-ordered: node n has children 2n+1 and 2n+2.
  // a node bit of 0 points at the lower-numbered half as the LRU side.
  localparam int LEVELS = $clog2(WAYS);

  // follow the stored pointers from the root down to a leaf.
  always_comb begin
    int node;
    node = 0;
    lru_way_o = '0;
    for (int lvl = 0; lvl < LEVELS; lvl++) begin
      lru_way_o[LEVELS-1-lvl] = lru_i[node];
      node = 2 * node + 1 + int'(lru_i[node]);
    end
  end

  // walk the path of way_i and point every node on it the other way,
  // which leaves way_i as the most recently used line.
  always_comb begin
    int   node;
    logic side;
    node = 0;
    upd_data_o = '0;
    upd_mask_o = '0;
    for (int lvl = 0; lvl < LEVELS; lvl++) begin
      side = way_i[LEVELS-1-lvl];
      upd_mask_o[node] = 1'b1;
      upd_data_o[node] = ~side;
      node = 2 * node + 1 + int'(side);
    end
  end

endmodule

// File: victim_select.sv
// ----------------------------------------------------------------------
// replacement way choice, lowest invalid way or the LRU way.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module victim_select (
  input  cache_geom_pkg::way_vec_t valid_i,
  input  cache_geom_pkg::way_id_t  lru_way_i,
  output cache_geom_pkg::way_id_t  victim_way_o
);

  import cache_geom_pkg::*;

  logic    invalid_found;
  way_id_t invalid_way;

  // scanning from the top down lets the lowest invalid way overwrite
  // any higher one, so the result is a low-to-high priority encode.
  always_comb begin
    invalid_found = 1'b0;
    invalid_way = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        invalid_found = 1'b1;
        invalid_way = way_id_t'(w);
      end
    end
  end

  // an empty way is always cheaper than displacing a live line.
  assign victim_way_o = invalid_found ? invalid_way : lru_way_i;

endmodule

// File: meta_write_gen.sv
// ----------------------------------------------------------------------
// stat and tag memory write commands for flush clears and fill commits.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module meta_write_gen (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  miss_if_pkg::meta_op_e     op_i,
  input  miss_if_pkg::miss_req_s    req_i,
  input  cache_geom_pkg::way_id_t   way_i,
  input  cache_geom_pkg::lru_bits_t upd_data_i,
  input  cache_geom_pkg::lru_bits_t upd_mask_i,
  output miss_if_pkg::stat_wr_s     stat_wr_o,
  output miss_if_pkg::tag_wr_s      tag_wr_o
);

  import cache_geom_pkg::*;
  import miss_if_pkg::*;

  way_vec_t way_onehot;
  index_t   req_index;
  tag_t     req_tag;
  logic     inv_op;

  assign way_onehot = way_vec_t'(1) << way_i;
  assign req_index  = addr_index(req_i.addr);
  assign req_tag    = addr_tag(req_i.addr);
  assign inv_op     = req_i.ainv_op | req_i.aflinv_op;

  always_comb begin
    stat_wr_o = '0;
    tag_wr_o = '0;
    stat_wr_o.index = req_index;
    tag_wr_o.index = req_index;

    case (op_i)
      // the flushed line is clean afterwards, whether or not it was
      // written back. LRU bits are left alone.
      e_meta_flush_clear: begin
        stat_wr_o.valid = 1'b1;
        stat_wr_o.mask.dirty = way_onehot;
        if (inv_op) begin
          tag_wr_o.valid = 1'b1;
          for (int w = 0; w < WAYS; w++) begin
            tag_wr_o.mask[w].valid = way_onehot[w];
          end
        end
      end

      // a new line arrives: dirty only if a store caused the miss,
      // and the filled way becomes the MRU line of the set.
      e_meta_fill_commit: begin
        stat_wr_o.valid = 1'b1;
        stat_wr_o.data.dirty = {WAYS{req_i.st_op}};
        stat_wr_o.mask.dirty = way_onehot;
        stat_wr_o.data.lru = upd_data_i;
        stat_wr_o.mask.lru = upd_mask_i;
        tag_wr_o.valid = 1'b1;
        for (int w = 0; w < WAYS; w++) begin
          tag_wr_o.data[w].valid = 1'b1;
          tag_wr_o.data[w].tag = req_tag;
          tag_wr_o.mask[w].valid = way_onehot[w];
          tag_wr_o.mask[w].tag = {TAG_WIDTH{way_onehot[w]}};
        end
      end

      default: begin
      end
    endcase
  end

  // a fill commit is requested only for a load or store miss and a
  // flush clear only for a flush.
  a_op_matches_req: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (op_i != e_meta_none) |->
      ((op_i == e_meta_fill_commit) == (req_i.ld_op || req_i.st_op))
  );

endmodule

// File: miss_fsm.sv
// ----------------------------------------------------------------------
// miss controller FSM with DMA command generation and pipeline handshake.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module miss_fsm (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     miss_v_i,
  input  logic                     sbuf_empty_i,
  input  miss_if_pkg::miss_req_s   req_i,
  input  miss_if_pkg::way_meta_s   meta_i,
  input  miss_if_pkg::stat_info_s  stat_i,
  input  cache_geom_pkg::way_id_t  victim_way_i,
  input  logic                     dma_done_i,
  input  logic                     ack_i,
  output logic                     stat_rd_o,
  output miss_if_pkg::dma_req_s    dma_o,
  output miss_if_pkg::meta_op_e    meta_op_o,
  output cache_geom_pkg::way_id_t  chosen_way_o,
  output logic                     recover_o,
  output logic                     done_o
);

  import cache_geom_pkg::*;
  import miss_if_pkg::*;

  typedef enum logic [2:0] {
    START,
    FLUSH_OP,
    SEND_FILL_ADDR,
    SEND_EVICT_ADDR,
    SEND_EVICT_DATA,
    GET_FILL_DATA,
    RECOVER,
    DONE
  } miss_state_e;

  miss_state_e state_r;
  miss_state_e state_n;
  way_id_t     chosen_way_r;
  way_id_t     chosen_way_n;
  logic        start;
  logic        flush_op;
  index_t      req_index;
  addr_t       fill_addr;
  addr_t       evict_addr;

  // the store buffer must be empty so no pending store races the fill.
  assign start      = miss_v_i & sbuf_empty_i;
  assign flush_op   = req_i.afl_op | req_i.ainv_op | req_i.aflinv_op;
  assign req_index  = addr_index(req_i.addr);
  assign fill_addr  = line_addr(addr_tag(req_i.addr), req_index);
  assign evict_addr = line_addr(meta_i.tag[chosen_way_r], req_index);

  assign chosen_way_o = chosen_way_r;

  always_comb begin
    state_n = state_r;
    chosen_way_n = chosen_way_r;
    stat_rd_o = 1'b0;
    dma_o.cmd = e_dma_nop;
    dma_o.way = chosen_way_r;
    dma_o.addr = fill_addr;
    meta_op_o = e_meta_none;
    recover_o = 1'b0;
    done_o = 1'b0;

    case (state_r)
      // the hit way is taken on entry so that the flush clear in the
      // next cycle already addresses it.
      START: begin
        stat_rd_o = start;
        if (start) begin
          if (flush_op) begin
            chosen_way_n = meta_i.hit_way;
            state_n = FLUSH_OP;
          end else begin
            state_n = SEND_FILL_ADDR;
          end
        end
      end

      FLUSH_OP: begin
        meta_op_o = e_meta_flush_clear;
        if (!req_i.ainv_op && stat_i.dirty[chosen_way_r] && meta_i.valid[chosen_way_r]) begin
          state_n = SEND_EVICT_ADDR;
        end else begin
          state_n = RECOVER;
        end
      end

      // stat data is valid from here on, so the victim is decided now.
      SEND_FILL_ADDR: begin
        chosen_way_n = victim_way_i;
        dma_o.cmd = e_dma_send_fill_addr;
        dma_o.way = victim_way_i;
        if (dma_done_i) begin
          if (stat_i.dirty[victim_way_i] && meta_i.valid[victim_way_i]) begin
            state_n = SEND_EVICT_ADDR;
          end else begin
            state_n = GET_FILL_DATA;
          end
        end
      end

      SEND_EVICT_ADDR: begin
        dma_o.cmd = e_dma_send_evict_addr;
        dma_o.addr = evict_addr;
        if (dma_done_i) begin
          state_n = SEND_EVICT_DATA;
        end
      end

      // flushes end after the write-back, misses continue with the fill.
      SEND_EVICT_DATA: begin
        dma_o.cmd = e_dma_send_evict_data;
        dma_o.addr = evict_addr;
        if (dma_done_i) begin
          state_n = flush_op ? RECOVER : GET_FILL_DATA;
        end
      end

      GET_FILL_DATA: begin
        dma_o.cmd = e_dma_get_fill_data;
        if (dma_done_i) begin
          meta_op_o = e_meta_fill_commit;
          state_n = RECOVER;
        end
      end

      // one cycle for the pipeline to re-read tag and data memories.
      RECOVER: begin
        recover_o = 1'b1;
        state_n = DONE;
      end

      DONE: begin
        done_o = 1'b1;
        if (ack_i) begin
          state_n = START;
        end
      end

      default: begin
        state_n = START;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= START;
      chosen_way_r <= '0;
    end else begin
      state_r <= state_n;
      chosen_way_r <= chosen_way_n;
    end
  end

  a_one_op: assert property (
    @(posedge clk_i) disable iff (reset_i)
    miss_v_i |-> $onehot0({req_i.ld_op, req_i.st_op, req_i.afl_op,
                           req_i.ainv_op, req_i.aflinv_op})
  );

  // a DMA request stays unchanged until the engine returns done.
  a_dma_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (dma_o.cmd != e_dma_nop && !dma_done_i) |=> $stable(dma_o)
  );

  // the pipeline acknowledges only a finished miss.
  a_ack_in_done: assert property (
    @(posedge clk_i) disable iff (reset_i)
    ack_i |-> done_o
  );

endmodule

// File: cache_miss_unit.sv
// ----------------------------------------------------------------------
// miss-handling unit top: controller, LRU tree, victim choice, writes.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cache_miss_unit (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     miss_v_i,
  input  logic                     sbuf_empty_i,
  input  miss_if_pkg::miss_req_s   req_i,
  input  miss_if_pkg::way_meta_s   meta_i,
  input  miss_if_pkg::stat_info_s  stat_i,
  input  logic                     dma_done_i,
  input  logic                     ack_i,
  output logic                     stat_rd_o,
  output miss_if_pkg::dma_req_s    dma_o,
  output miss_if_pkg::stat_wr_s    stat_wr_o,
  output miss_if_pkg::tag_wr_s     tag_wr_o,
  output cache_geom_pkg::way_id_t  chosen_way_o,
  output logic                     recover_o,
  output logic                     done_o
);

  import cache_geom_pkg::*;
  import miss_if_pkg::*;

  way_id_t   lru_way;
  way_id_t   victim_way;
  lru_bits_t lru_upd_data;
  lru_bits_t lru_upd_mask;
  meta_op_e  meta_op;

  miss_fsm u_miss_fsm (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .miss_v_i     (miss_v_i),
    .sbuf_empty_i (sbuf_empty_i),
    .req_i        (req_i),
    .meta_i       (meta_i),
    .stat_i       (stat_i),
    .victim_way_i (victim_way),
    .dma_done_i   (dma_done_i),
    .ack_i        (ack_i),
    .stat_rd_o    (stat_rd_o),
    .dma_o        (dma_o),
    .meta_op_o    (meta_op),
    .chosen_way_o (chosen_way_o),
    .recover_o    (recover_o),
    .done_o       (done_o)
  );

  // the update path is driven by the registered way, which is the one
  // that the fill commit writes.
  plru_tree u_plru_tree (
    .lru_i      (stat_i.lru),
    .way_i      (chosen_way_o),
    .lru_way_o  (lru_way),
    .upd_data_o (lru_upd_data),
    .upd_mask_o (lru_upd_mask)
  );

  victim_select u_victim_select (
    .valid_i      (meta_i.valid),
    .lru_way_i    (lru_way),
    .victim_way_o (victim_way)
  );

  meta_write_gen u_meta_write_gen (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .op_i       (meta_op),
    .req_i      (req_i),
    .way_i      (chosen_way_o),
    .upd_data_i (lru_upd_data),
    .upd_mask_i (lru_upd_mask),
    .stat_wr_o  (stat_wr_o),
    .tag_wr_o   (tag_wr_o)
  );

endmodule

// File: tb_cache_miss_unit.sv
// ----------------------------------------------------------------------
// directed testbench of the miss unit with DMA, stat memory and
// pipeline models, a value check task and a cycle timeout.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_cache_miss_unit;

  import cache_geom_pkg::*;
  import miss_if_pkg::*;

  // five tests of at most about 40 cycles each, two resets and margin.
  localparam int TIMEOUT_CYCLES = 300;

  logic       clk_i = 1'b0;
  logic       reset_i;
  logic       miss_v_i;
  logic       sbuf_empty_i;
  miss_req_s  req_i;
  way_meta_s  meta_i;
  stat_info_s stat_i = '0;
  logic       dma_done_i = 1'b0;
  logic       ack_i;
  logic       stat_rd_o;
  dma_req_s   dma_o;
  stat_wr_s   stat_wr_o;
  tag_wr_s    tag_wr_o;
  way_id_t    chosen_way_o;
  logic       recover_o;
  logic       done_o;

  // DMA model state and the recorded command sequence.
  logic [15:0] lfsr = 16'd14;
  logic        dma_busy = 1'b0;
  int          dma_wait = 0;
  dma_cmd_e    dma_cmd_q[$];
  addr_t       dma_addr_q[$];
  way_id_t     dma_way_q[$];

  // monitor records of the current miss.
  stat_info_s stat_word = '0;
  stat_wr_s   last_stat_wr;
  tag_wr_s    last_tag_wr;
  int         wr_count;
  int         wr_cycle;
  int         recover_count;
  int         recover_cycle;
  int         done_cycle;
  int         stat_rd_count;
  int         stat_rd_cycle;
  logic       rd_bad;
  int         cycle = 0;
  int         timeout_count = 0;
  int         error_count = 0;

  cache_miss_unit u_cache_miss_unit (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .miss_v_i     (miss_v_i),
    .sbuf_empty_i (sbuf_empty_i),
    .req_i        (req_i),
    .meta_i       (meta_i),
    .stat_i       (stat_i),
    .dma_done_i   (dma_done_i),
    .ack_i        (ack_i),
    .stat_rd_o    (stat_rd_o),
    .dma_o        (dma_o),
    .stat_wr_o    (stat_wr_o),
    .tag_wr_o     (tag_wr_o),
    .chosen_way_o (chosen_way_o),
    .recover_o    (recover_o),
    .done_o       (done_o)
  );

  always #20 clk_i = ~clk_i;

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // each command gets a delay of 0 to 3 cycles, two LFSR bits.
  always @(posedge clk_i) begin
    if (reset_i) begin
      dma_done_i <= 1'b0;
      dma_busy = 1'b0;
    end else if (dma_done_i) begin
      dma_done_i <= 1'b0;
    end else if (dma_o.cmd != e_dma_nop) begin
      if (!dma_busy) begin
        dma_cmd_q.push_back(dma_o.cmd);
        dma_addr_q.push_back(dma_o.addr);
        dma_way_q.push_back(dma_o.way);
        lfsr = lfsr_next(lfsr);
        dma_wait = int'(lfsr[0]);
        lfsr = lfsr_next(lfsr);
        dma_wait = dma_wait + 2 * int'(lfsr[0]);
        dma_busy = 1'b1;
      end
      if (dma_wait == 0) begin
        dma_done_i <= 1'b1;
        dma_busy = 1'b0;
      end else begin
        dma_wait--;
      end
    end
  end

  // stat memory returns the word one cycle after the read enable.
  always @(posedge clk_i) begin
    if (stat_rd_o) begin
      stat_i <= stat_word;
    end
  end

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (stat_wr_o.valid || tag_wr_o.valid) begin
        wr_count++;
        wr_cycle = cycle;
        last_stat_wr = stat_wr_o;
        last_tag_wr = tag_wr_o;
      end
      if (recover_o) begin
        recover_count++;
        recover_cycle = cycle;
      end
      if (done_o && done_cycle < 0) begin
        done_cycle = cycle;
      end
      if (stat_rd_o) begin
        stat_rd_count++;
        stat_rd_cycle = cycle;
        if (!sbuf_empty_i) begin
          rd_bad = 1'b1;
        end
      end
    end
    cycle++;
  end

  always @(posedge clk_i) begin
    timeout_count++;
    if (timeout_count > TIMEOUT_CYCLES) begin
      $display("TESTS FAILED");
      $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  task automatic clear_records();
    dma_cmd_q.delete();
    dma_addr_q.delete();
    dma_way_q.delete();
    wr_count = 0;
    wr_cycle = -1;
    recover_count = 0;
    recover_cycle = -1;
    done_cycle = -1;
    stat_rd_count = 0;
    stat_rd_cycle = -1;
    rd_bad = 1'b0;
  endtask

  task automatic check_idle_outputs();
    check_value("done_o", 64'(done_o), 64'(0));
    check_value("recover_o", 64'(recover_o), 64'(0));
    check_value("stat_rd_o", 64'(stat_rd_o), 64'(0));
    check_value("stat_wr_o.valid", 64'(stat_wr_o.valid), 64'(0));
    check_value("tag_wr_o.valid", 64'(tag_wr_o.valid), 64'(0));
    check_value("dma_o.cmd", 64'(dma_o.cmd), 64'(e_dma_nop));
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    reset_i <= 1'b1;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic check_dma(input int idx, input dma_cmd_e cmd, input addr_t addr);
    check_value($sformatf("dma_o.cmd #%0d", idx), 64'(dma_cmd_q[idx]), 64'(cmd));
    check_value($sformatf("dma_o.addr #%0d", idx), 64'(dma_addr_q[idx]), 64'(addr));
  endtask

  // one miss from request to acknowledge, with the handshake checks.
  task automatic run_miss(input miss_req_s req, input way_meta_s meta,
                          input stat_info_s stat, input int sbuf_wait,
                          input int ack_wait);
    @(negedge clk_i);
    clear_records();
    stat_word = stat;
    @(posedge clk_i);
    miss_v_i <= 1'b1;
    req_i <= req;
    meta_i <= meta;
    sbuf_empty_i <= (sbuf_wait == 0);
    repeat (sbuf_wait) begin
      @(posedge clk_i);
      check_value("stat_rd_o", 64'(stat_rd_o), 64'(0));
    end
    sbuf_empty_i <= 1'b1;
    @(posedge clk_i);
    while (!done_o) @(posedge clk_i);
    repeat (ack_wait) begin
      @(posedge clk_i);
      check_value("done_o", 64'(done_o), 64'(1));
    end
    ack_i <= 1'b1;
    @(posedge clk_i);
    check_value("done_o", 64'(done_o), 64'(1));
    ack_i <= 1'b0;
    miss_v_i <= 1'b0;
    @(posedge clk_i);
    check_idle_outputs();
    check_value("recover_o pulses", 64'(recover_count), 64'(1));
    check_value("done_o rise cycle", 64'(done_cycle), 64'(recover_cycle + 1));
    check_value("stat_rd_o pulses", 64'(stat_rd_count), 64'(1));
    check_value("stat_rd_o with busy store buffer", 64'(rd_bad), 64'(0));
  endtask

  task automatic load_miss_invalid_way_test(input int sbuf_wait, input int ack_wait);
    miss_req_s  req;
    way_meta_s  meta;
    stat_info_s stat;
    req = '0;
    req.addr = 32'h1234_5678;
    req.ld_op = 1'b1;
    meta = '0;
    meta.tag[0] = 21'h00111;
    meta.tag[2] = 21'h00222;
    meta.valid = 4'b0101;
    // the LRU bits point at way 0, but the empty way 1 must win.
    stat.dirty = 4'b0000;
    stat.lru = 3'b000;
    run_miss(req, meta, stat, sbuf_wait, ack_wait);
    check_value("dma command count", 64'(dma_cmd_q.size()), 64'(2));
    check_dma(0, e_dma_send_fill_addr, 32'h1234_5660);
    check_dma(1, e_dma_get_fill_data, 32'h1234_5660);
    check_value("meta write count", 64'(wr_count), 64'(1));
    check_value("fill commit cycle", 64'(wr_cycle), 64'(recover_cycle - 1));
    check_value("stat_wr_o.index", 64'(last_stat_wr.index), 64'(req.addr[10:5]));
    check_value("stat_wr_o.mask.dirty", 64'(last_stat_wr.mask.dirty), 64'(4'b0010));
    check_value("stat_wr_o.data.dirty[1]", 64'(last_stat_wr.data.dirty[1]), 64'(0));
    // way 1 path: root points up to 1, lower node points to way 0.
    check_value("stat_wr_o.mask.lru", 64'(last_stat_wr.mask.lru), 64'(3'b011));
    check_value("stat_wr_o.data.lru", 64'(last_stat_wr.data.lru), 64'(3'b001));
    check_value("tag_wr_o.valid", 64'(last_tag_wr.valid), 64'(1));
    check_value("tag_wr_o.mask[1].valid", 64'(last_tag_wr.mask[1].valid), 64'(1));
    check_value("tag_wr_o.mask[0].valid", 64'(last_tag_wr.mask[0].valid), 64'(0));
    check_value("tag_wr_o.data[1].valid", 64'(last_tag_wr.data[1].valid), 64'(1));
    check_value("tag_wr_o.data[1].tag", 64'(last_tag_wr.data[1].tag), 64'(req.addr[31:11]));
    check_value("chosen_way_o", 64'(chosen_way_o), 64'(1));
  endtask

  task automatic store_miss_dirty_lru_test();
    miss_req_s  req;
    way_meta_s  meta;
    stat_info_s stat;
    addr_t      evict;
    req = '0;
    req.addr = 32'hA5A5_03C4;
    req.st_op = 1'b1;
    meta = '0;
    meta.tag[0] = 21'h00010;
    meta.tag[1] = 21'h00020;
    meta.tag[2] = 21'h00030;
    meta.tag[3] = 21'h0ABCD;
    meta.valid = 4'b1111;
    stat.dirty = 4'b1000;
    stat.lru = 3'b101;
    evict = {21'h0ABCD, req.addr[10:5], 5'b00000};
    run_miss(req, meta, stat, 0, 0);
    check_value("dma command count", 64'(dma_cmd_q.size()), 64'(4));
    check_dma(0, e_dma_send_fill_addr, 32'hA5A5_03C0);
    check_dma(1, e_dma_send_evict_addr, evict);
    check_dma(2, e_dma_send_evict_data, evict);
    check_dma(3, e_dma_get_fill_data, 32'hA5A5_03C0);
    check_value("dma_o.way", 64'(dma_way_q[0]), 64'(3));
    check_value("meta write count", 64'(wr_count), 64'(1));
    check_value("stat_wr_o.mask.dirty", 64'(last_stat_wr.mask.dirty), 64'(4'b1000));
    check_value("stat_wr_o.data.dirty[3]", 64'(last_stat_wr.data.dirty[3]), 64'(1));
    check_value("stat_wr_o.mask.lru", 64'(last_stat_wr.mask.lru), 64'(3'b101));
    check_value("stat_wr_o.data.lru", 64'(last_stat_wr.data.lru), 64'(3'b000));
    check_value("tag_wr_o.data[3].tag", 64'(last_tag_wr.data[3].tag), 64'(req.addr[31:11]));
    check_value("chosen_way_o", 64'(chosen_way_o), 64'(3));
  endtask

  task automatic flush_test();
    miss_req_s  req;
    way_meta_s  meta;
    stat_info_s stat;
    req = '0;
    req.addr = 32'h00C0_FFE4;
    req.afl_op = 1'b1;
    meta = '0;
    meta.tag[2] = req.addr[31:11];
    meta.valid = 4'b1111;
    meta.hit = 4'b0100;
    meta.hit_way = 2'd2;
    meta.hit_found = 1'b1;
    stat.dirty = 4'b0100;
    stat.lru = 3'b000;
    run_miss(req, meta, stat, 0, 0);
    check_value("meta write count", 64'(wr_count), 64'(1));
    check_value("flush clear cycle", 64'(wr_cycle), 64'(stat_rd_cycle + 1));
    check_value("stat_wr_o.mask.dirty", 64'(last_stat_wr.mask.dirty), 64'(4'b0100));
    check_value("stat_wr_o.data.dirty", 64'(last_stat_wr.data.dirty), 64'(0));
    check_value("tag_wr_o.valid", 64'(last_tag_wr.valid), 64'(0));
    check_value("dma command count", 64'(dma_cmd_q.size()), 64'(2));
    check_dma(0, e_dma_send_evict_addr, 32'h00C0_FFE0);
    check_dma(1, e_dma_send_evict_data, 32'h00C0_FFE0);
    check_value("chosen_way_o", 64'(chosen_way_o), 64'(2));

    // invalidate only, the dirty line is dropped without a write-back.
    req.afl_op = 1'b0;
    req.ainv_op = 1'b1;
    meta.tag[1] = req.addr[31:11];
    meta.hit = 4'b0010;
    meta.hit_way = 2'd1;
    stat.dirty = 4'b0010;
    run_miss(req, meta, stat, 0, 0);
    check_value("meta write count", 64'(wr_count), 64'(1));
    check_value("stat_wr_o.mask.dirty", 64'(last_stat_wr.mask.dirty), 64'(4'b0010));
    check_value("tag_wr_o.valid", 64'(last_tag_wr.valid), 64'(1));
    check_value("tag_wr_o.mask[1].valid", 64'(last_tag_wr.mask[1].valid), 64'(1));
    check_value("tag_wr_o.data[1].valid", 64'(last_tag_wr.data[1].valid), 64'(0));
    check_value("dma command count", 64'(dma_cmd_q.size()), 64'(0));
  endtask

  // reset hits while a DMA command of a store miss is outstanding.
  task automatic reset_during_miss_test();
    miss_req_s req;
    req = '0;
    req.addr = 32'h0000_1F00;
    req.st_op = 1'b1;
    @(posedge clk_i);
    miss_v_i <= 1'b1;
    req_i <= req;
    meta_i <= '0;
    @(posedge clk_i);
    while (dma_o.cmd == e_dma_nop) @(posedge clk_i);
    miss_v_i <= 1'b0;
    apply_reset();
    check_idle_outputs();
  endtask

  initial begin
    reset_i <= 1'b1;
    miss_v_i <= 1'b0;
    sbuf_empty_i <= 1'b1;
    req_i <= '0;
    meta_i <= '0;
    ack_i <= 1'b0;
    clear_records();
    apply_reset();
    check_idle_outputs();

    load_miss_invalid_way_test(0, 0);
    store_miss_dirty_lru_test();
    flush_test();
    // handshake: busy store buffer for 3 cycles, ack withheld for 5.
    load_miss_invalid_way_test(3, 5);
    reset_during_miss_test();

    if (error_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "%0d checks failed", error_count);
    end
  end

endmodule

// File: cache_miss_unit.f
+incdir+.
cache_geom_pkg.sv
miss_if_pkg.sv
plru_tree.sv
victim_select.sv
meta_write_gen.sv
miss_fsm.sv
cache_miss_unit.sv
tb_cache_miss_unit.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_cache_miss_unit
FILELIST  := cache_miss_unit.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
